//--- source/corr_pkg.sv
package corr_pkg;

  // Width of FIFO entries and of every reported count
  localparam int BYTE_W = 8;

  // Window number followed by the four count bytes
  localparam int PKT_BYTES = 5;

  // Source of the byte shown on the PWM pin
  // Codes 5 and 6 are unused and show the window number
  typedef enum logic [2:0] {
    PWM_SEL_WIN_NUM       = 3'd0,
    PWM_SEL_COUNT_X       = 3'd1,
    PWM_SEL_COUNT_Y       = 3'd2,
    PWM_SEL_COUNT_ISECT   = 3'd3,
    PWM_SEL_COUNT_SYMDIFF = 3'd4,
    PWM_SEL_HAM           = 3'd7
  } pwm_sel_e;

endpackage

//--- source/sample_strobe.sv
`timescale 1ns/1ns

module sample_strobe #(
  parameter int MAX_SAMPLE_PERIOD_EXP = 6
) (
  input  logic                                     i_clk,
  input  logic                                     i_rst_n,
  input  logic                                     i_wr_config,
  input  logic [$clog2(MAX_SAMPLE_PERIOD_EXP+1)-1:0] i_sample_period_exp,
  output logic                                     o_sample_stb,
  output logic                                     o_count_stb
);

  localparam int PH_W  = MAX_SAMPLE_PERIOD_EXP;
  localparam int EXP_W = $clog2(MAX_SAMPLE_PERIOD_EXP + 1);

  logic [EXP_W-1:0] exp_q;
  logic             running_q;
  logic [PH_W-1:0]  phase_q;
  logic [PH_W-1:0]  mask;
  logic [PH_W-1:0]  phase_m;

  // Exponent is taken at the write, strobes stay off until the first one
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      exp_q     <= '0;
      running_q <= 1'b0;
    end else if (i_wr_config) begin
      exp_q     <= i_sample_period_exp;
      running_q <= 1'b1;
    end
  end

  // Free running phase, restarted by a configuration write
  // The counter width is a multiple of every period so no extra wrap is needed
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      phase_q <= '0;
    end else if (i_wr_config) begin
      phase_q <= '0;
    end else begin
      phase_q <= phase_q + 1'b1;
    end
  end

  // Low exp_q bits set, all ones when the exponent equals the counter width
  assign mask    = ~({PH_W{1'b1}} << exp_q);
  assign phase_m = phase_q & mask;

  // Sample at the end of the period, count half a period earlier
  // With a zero exponent both compares hold every cycle
  assign o_sample_stb = running_q && (phase_m == mask);
  assign o_count_stb  = running_q && (phase_m == (mask >> 1));

endmodule

//--- source/window_counter.sv
`timescale 1ns/1ns

module window_counter #(
  parameter int MAX_WINDOW_LENGTH_EXP = 10
) (
  input  logic                                     i_clk,
  input  logic                                     i_rst_n,
  input  logic                                     i_wr_config,
  input  logic [$clog2(MAX_WINDOW_LENGTH_EXP+1)-1:0] i_window_length_exp,
  input  logic                                     i_sample_stb,
  input  logic                                     i_count_stb,
  input  logic                                     i_x,
  input  logic                                     i_y,
  output logic                                     o_wrap,
  output logic [MAX_WINDOW_LENGTH_EXP-1:0]         o_count_x,
  output logic [MAX_WINDOW_LENGTH_EXP-1:0]         o_count_y,
  output logic [MAX_WINDOW_LENGTH_EXP-1:0]         o_count_isect,
  output logic [MAX_WINDOW_LENGTH_EXP-1:0]         o_count_symdiff
);

  localparam int TIME_W = MAX_WINDOW_LENGTH_EXP;
  localparam int EXP_W  = $clog2(MAX_WINDOW_LENGTH_EXP + 1);
  localparam int N_CNT  = 4;

  logic [EXP_W-1:0]  wexp_q;
  logic              x_q;
  logic              y_q;
  logic [TIME_W-1:0] t_q;
  logic [TIME_W-1:0] wmask;
  logic              last;
  logic [N_CNT-1:0]  hit;
  logic [TIME_W-1:0] cnt_q  [N_CNT];
  logic [TIME_W-1:0] cnt_nx [N_CNT];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wexp_q <= '0;
    end else if (i_wr_config) begin
      wexp_q <= i_window_length_exp;
    end
  end

  // Input samples, held between sampling strobes
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      x_q <= 1'b0;
      y_q <= 1'b0;
    end else if (i_sample_stb) begin
      x_q <= i_x;
      y_q <= i_y;
    end
  end

  // Window ends on the strobe where the low wexp_q bits of time are all set
  assign wmask  = ~({TIME_W{1'b1}} << wexp_q);
  assign last   = (t_q & wmask) == wmask;
  assign o_wrap = i_count_stb && last;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      t_q <= '0;
    end else if (i_wr_config) begin
      t_q <= '0;
    end else if (i_count_stb) begin
      t_q <= last ? '0 : t_q + 1'b1;
    end
  end

  // X, Y, intersection and symmetric difference
  assign hit = {x_q ^ y_q, x_q & y_q, y_q, x_q};

  always_comb begin
    for (int i = 0; i < N_CNT; i++) begin
      cnt_nx[i] = cnt_q[i] + {{(TIME_W-1){1'b0}}, hit[i]};
    end
  end

  // Totals restart at zero after the strobe that closes the window
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < N_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (i_wr_config) begin
      for (int i = 0; i < N_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (i_count_stb) begin
      for (int i = 0; i < N_CNT; i++) begin
        cnt_q[i] <= last ? '0 : cnt_nx[i];
      end
    end
  end

  // Totals include the sample counted on the wrap strobe
  assign o_count_x       = cnt_nx[0];
  assign o_count_y       = cnt_nx[1];
  assign o_count_isect   = cnt_nx[2];
  assign o_count_symdiff = cnt_nx[3];

endmodule

//--- source/pkt_builder.sv
`timescale 1ns/1ns

module pkt_builder #(
  parameter int TIME_W = 10
) (
  input  logic                                             i_clk,
  input  logic                                             i_rst_n,
  input  logic                                             i_flush,
  input  logic                                             i_wrap,
  input  logic [TIME_W-1:0]                                i_count_x,
  input  logic [TIME_W-1:0]                                i_count_y,
  input  logic [TIME_W-1:0]                                i_count_isect,
  input  logic [TIME_W-1:0]                                i_count_symdiff,
  output logic                                             o_push,
  output logic [corr_pkg::BYTE_W-1:0]                      o_push_data,
  output logic [corr_pkg::PKT_BYTES*corr_pkg::BYTE_W-1:0]  o_pkt_bytes
);

  import corr_pkg::*;

  localparam int PKT_W = PKT_BYTES * BYTE_W;

  logic [BYTE_W-1:0] win_num_q;
  logic [PKT_W-1:0]  pkt_q;
  logic [2:0]        idx_q;

  // Wrapping window number, lets the host spot dropped packets
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      win_num_q <= '0;
    end else if (i_wrap) begin
      win_num_q <= win_num_q + 1'b1;
    end
  end

  // Byte 0 is the window number, then the top byte of each count
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pkt_q <= '0;
    end else if (i_wrap) begin
      pkt_q <= {i_count_symdiff[TIME_W-1 -: BYTE_W],
                i_count_isect[TIME_W-1 -: BYTE_W],
                i_count_y[TIME_W-1 -: BYTE_W],
                i_count_x[TIME_W-1 -: BYTE_W],
                win_num_q};
    end
  end

  // Index 0 is idle, 1 to PKT_BYTES select the byte being pushed
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      idx_q <= '0;
    end else if (i_flush) begin
      idx_q <= '0;
    end else if (i_wrap) begin
      idx_q <= 3'd1;
    end else if (idx_q == 3'(PKT_BYTES)) begin
      idx_q <= '0;
    end else if (idx_q != '0) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  assign o_push = (idx_q != '0);

  always_comb begin
    case (idx_q)
      3'd2:    o_push_data = pkt_q[1*BYTE_W +: BYTE_W];
      3'd3:    o_push_data = pkt_q[2*BYTE_W +: BYTE_W];
      3'd4:    o_push_data = pkt_q[3*BYTE_W +: BYTE_W];
      3'd5:    o_push_data = pkt_q[4*BYTE_W +: BYTE_W];
      default: o_push_data = pkt_q[0 +: BYTE_W];
    endcase
  end

  assign o_pkt_bytes = pkt_q;

endmodule

//--- source/pkt_fifo.sv
`timescale 1ns/1ns

module pkt_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_flush,
  input  logic                        i_push,
  input  logic [corr_pkg::BYTE_W-1:0] i_push_data,
  input  logic                        i_pop,
  output logic [corr_pkg::BYTE_W-1:0] o_data,
  output logic                        o_empty
);

  import corr_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [BYTE_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [PTR_W-1:0]  wr_ptr_nx;
  logic [PTR_W-1:0]  rd_ptr_nx;
  logic [CNT_W-1:0]  count_q;
  logic [BYTE_W-1:0] head_q;
  logic              full;
  logic              do_push;
  logic              do_pop;

  assign full    = (count_q == CNT_W'(DEPTH));
  assign o_empty = (count_q == '0);

  // Full drops the push, empty ignores the pop
  assign do_push = i_push && !full;
  assign do_pop  = i_pop && !o_empty;

  assign wr_ptr_nx = (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
  assign rd_ptr_nx = (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= i_push_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (i_flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_nx;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_nx;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // Show-ahead head register, a copy of the oldest entry
  // The next head bypasses memory when it is being written this cycle
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      head_q <= '0;
    end else if (!i_flush) begin
      if (do_pop) begin
        if (count_q > CNT_W'(1)) begin
          head_q <= mem[rd_ptr_nx];
        end else if (do_push) begin
          head_q <= i_push_data;
        end
      end else if (o_empty && do_push) begin
        head_q <= i_push_data;
      end
    end
  end

  assign o_data = head_q;

endmodule

//--- source/pwm_monitor.sv
`timescale 1ns/1ns

module pwm_monitor (
  input  logic                                            i_clk,
  input  logic                                            i_rst_n,
  input  corr_pkg::pwm_sel_e                              i_pwm_select,
  input  logic [corr_pkg::PKT_BYTES*corr_pkg::BYTE_W-1:0] i_pkt_bytes,
  output logic                                            o_pwm
);

  import corr_pkg::*;

  logic [BYTE_W-1:0] level;
  logic [BYTE_W-1:0] level_q;
  logic [BYTE_W-1:0] acc_q;
  logic [BYTE_W:0]   sum;

  // Byte order follows the packet, window number first
  always_comb begin
    case (i_pwm_select)
      PWM_SEL_COUNT_X:       level = i_pkt_bytes[1*BYTE_W +: BYTE_W];
      PWM_SEL_COUNT_Y:       level = i_pkt_bytes[2*BYTE_W +: BYTE_W];
      PWM_SEL_COUNT_ISECT:   level = i_pkt_bytes[3*BYTE_W +: BYTE_W];
      PWM_SEL_COUNT_SYMDIFF: level = i_pkt_bytes[4*BYTE_W +: BYTE_W];
      // Hamming similarity is one minus the symmetric difference rate
      PWM_SEL_HAM:           level = ~i_pkt_bytes[4*BYTE_W +: BYTE_W];
      default:               level = i_pkt_bytes[0 +: BYTE_W];
    endcase
  end

  // First order delta-sigma, the carry out is high level_q times per 256 cycles
  assign sum = {1'b0, acc_q} + {1'b0, level_q};

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      level_q <= '0;
      acc_q   <= '0;
      o_pwm   <= 1'b0;
    end else begin
      level_q <= level;
      acc_q   <= sum[BYTE_W-1:0];
      o_pwm   <= sum[BYTE_W];
    end
  end

endmodule

//--- source/correlator_top.sv
`timescale 1ns/1ns

module correlator_top #(
  parameter int MAX_WINDOW_LENGTH_EXP = 10,
  parameter int MAX_SAMPLE_PERIOD_EXP = 6,
  parameter int PKTFIFO_DEPTH         = 16
) (
  input  logic                                       i_clk,
  input  logic                                       i_rst_n,
  input  logic                                       i_wr_config,
  input  logic [$clog2(MAX_SAMPLE_PERIOD_EXP+1)-1:0] i_sample_period_exp,
  input  logic [$clog2(MAX_WINDOW_LENGTH_EXP+1)-1:0] i_window_length_exp,
  input  corr_pkg::pwm_sel_e                         i_pwm_select,
  input  logic                                       i_x,
  input  logic                                       i_y,
  input  logic                                       i_pktfifo_pop,
  input  logic                                       i_pktfifo_flush,
  output logic [corr_pkg::BYTE_W-1:0]                o_pktfifo_data,
  output logic                                       o_pktfifo_empty,
  output logic                                       o_pwm
);

  import corr_pkg::*;

  // Counts are as wide as the longest window exponent
  localparam int TIME_W = MAX_WINDOW_LENGTH_EXP;

  logic                        sample_stb;
  logic                        count_stb;
  logic                        wrap;
  logic [TIME_W-1:0]           count_x;
  logic [TIME_W-1:0]           count_y;
  logic [TIME_W-1:0]           count_isect;
  logic [TIME_W-1:0]           count_symdiff;
  logic                        push;
  logic [BYTE_W-1:0]           push_data;
  logic [PKT_BYTES*BYTE_W-1:0] pkt_bytes;

  sample_strobe #(
    .MAX_SAMPLE_PERIOD_EXP (MAX_SAMPLE_PERIOD_EXP)
  ) u_sample_strobe (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .i_wr_config         (i_wr_config),
    .i_sample_period_exp (i_sample_period_exp),
    .o_sample_stb        (sample_stb),
    .o_count_stb         (count_stb)
  );

  window_counter #(
    .MAX_WINDOW_LENGTH_EXP (MAX_WINDOW_LENGTH_EXP)
  ) u_window_counter (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .i_wr_config         (i_wr_config),
    .i_window_length_exp (i_window_length_exp),
    .i_sample_stb        (sample_stb),
    .i_count_stb         (count_stb),
    .i_x                 (i_x),
    .i_y                 (i_y),
    .o_wrap              (wrap),
    .o_count_x           (count_x),
    .o_count_y           (count_y),
    .o_count_isect       (count_isect),
    .o_count_symdiff     (count_symdiff)
  );

  pkt_builder #(
    .TIME_W (TIME_W)
  ) u_pkt_builder (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_flush         (i_pktfifo_flush),
    .i_wrap          (wrap),
    .i_count_x       (count_x),
    .i_count_y       (count_y),
    .i_count_isect   (count_isect),
    .i_count_symdiff (count_symdiff),
    .o_push          (push),
    .o_push_data     (push_data),
    .o_pkt_bytes     (pkt_bytes)
  );

  pkt_fifo #(
    .DEPTH (PKTFIFO_DEPTH)
  ) u_pkt_fifo (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_flush     (i_pktfifo_flush),
    .i_push      (push),
    .i_push_data (push_data),
    .i_pop       (i_pktfifo_pop),
    .o_data      (o_pktfifo_data),
    .o_empty     (o_pktfifo_empty)
  );

  pwm_monitor u_pwm_monitor (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pwm_select (i_pwm_select),
    .i_pkt_bytes  (pkt_bytes),
    .o_pwm        (o_pwm)
  );

endmodule

//--- sim/correlator_asserts.sv
`timescale 1ns/1ns

module correlator_asserts (
  input logic       i_clk,
  input logic       i_rst_n,
  input logic       i_empty,
  input logic [7:0] i_data,
  input logic       i_pop,
  input logic       i_flush,
  input logic       i_push,
  input logic       i_wrap
);

  import corr_pkg::*;

  // FIFO comes out of reset empty
  reset_empty: assert property (@(posedge i_clk) $rose(i_rst_n) |-> i_empty)
    else $error("FIFO not empty after reset release");

  // A burst carries one whole packet unless a flush cuts it short
  push_burst_len: assert property (@(posedge i_clk) disable iff (!i_rst_n || i_flush)
    $rose(i_push) |-> i_push [*PKT_BYTES] ##1 !i_push)
    else $error("push burst length differs from packet size");

  push_wrap_apart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_push && i_wrap))
    else $error("push overlaps window wrap");

  // Head stays put when an empty FIFO sees a pop
  empty_pop_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_pop && i_empty && !i_push && !i_flush) |=> $stable(i_data))
    else $error("pop while empty changed FIFO output");

endmodule

bind correlator_top correlator_asserts u_correlator_asserts (
  .i_clk   (i_clk),
  .i_rst_n (i_rst_n),
  .i_empty (o_pktfifo_empty),
  .i_data  (o_pktfifo_data),
  .i_pop   (i_pktfifo_pop),
  .i_flush (i_pktfifo_flush),
  .i_push  (push),
  .i_wrap  (wrap)
);

//--- sim/correlator_tb.sv
`timescale 1ns/1ns

module correlator_tb;

  import corr_pkg::*;

  localparam int RST_CYCLES = 16;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       wr_config;
  logic [2:0] sp_exp;
  logic [3:0] wl_exp;
  pwm_sel_e   pwm_select;
  logic       x;
  logic       y;
  logic       pop;
  logic       flush;
  logic [7:0] fifo_data;
  logic       empty;
  logic       pwm;

  int          mismatches = 0;
  int          failures = 0;
  logic [31:0] lcg_state = 32'h6d85;
  longint      budget = 0;
  bit          budget_ready = 1'b0;

  // One stimulus table entry per file line
  int          s_p[$];
  int          s_w[$];
  int          s_sel[$];
  int          s_n[$];
  logic [15:0] s_x[$];
  logic [15:0] s_y[$];
  int          s_ex[$];
  int          s_ey[$];
  int          s_ei[$];
  int          s_es[$];

  logic [7:0] rx[$];
  int         exp_win;
  bit         win_valid = 1'b0;

  correlator_top correlator_top_i (
    .i_clk               (clk),
    .i_rst_n             (rst_n),
    .i_wr_config         (wr_config),
    .i_sample_period_exp (sp_exp),
    .i_window_length_exp (wl_exp),
    .i_pwm_select        (pwm_select),
    .i_x                 (x),
    .i_y                 (y),
    .i_pktfifo_pop       (pop),
    .i_pktfifo_flush     (flush),
    .o_pktfifo_data      (fifo_data),
    .o_pktfifo_empty     (empty),
    .o_pwm               (pwm)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    failures++;
    $display("ERROR %s", msg);
  endtask

  task automatic print_summary();
    $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
  endtask

  task automatic read_stim();
    int    fd;
    int    n;
    string line;
    int    p, w, sel, nw, ex, ey, ei, es;
    int    xp, yp;
    fd = $fopen("sim/correlator_stim.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open stimulus file sim/correlator_stim.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %d %d %h %h %d %h %h %h %h",
                  p, w, sel, xp, yp, nw, ex, ey, ei, es);
      if (n != 10) begin
        report_failure("malformed line in stimulus file");
        continue;
      end
      s_p.push_back(p);
      s_w.push_back(w);
      s_sel.push_back(sel);
      s_x.push_back(xp[15:0]);
      s_y.push_back(yp[15:0]);
      s_n.push_back(nw);
      s_ex.push_back(ex);
      s_ey.push_back(ey);
      s_ei.push_back(ei);
      s_es.push_back(es);
    end
    $fclose(fd);
  endtask

  // Window numbers count up by one from the first one seen
  task automatic check_win(input logic [7:0] b);
    if (win_valid) begin
      check_value("window number", b, exp_win[7:0]);
    end
    exp_win = b + 1;
    win_valid = 1'b1;
  endtask

  // Mode 0 plain, 1 back-pressure, 2 flush during the first burst
  task automatic check_packets(input int mode, input int k, input int idx);
    int pos;
    int need;
    need = (mode == 1) ? 5 * k - 4 : (mode == 2) ? 5 * (k - 1) : 5 * k;
    if (rx.size() != need) begin
      report_failure($sformatf("case %0d read %0d bytes instead of %0d",
                               idx, rx.size(), need));
      return;
    end
    pos = 0;
    for (int j = 0; j < k; j++) begin
      if (mode == 2 && j == 0) begin
        continue;
      end
      // Only the window number of the packet that hit the full FIFO survives
      if (mode == 1 && j == 4) begin
        check_win(rx[pos]);
        pos++;
        continue;
      end
      check_win(rx[pos]);
      if (j > 0 || mode == 2) begin
        check_value("count x byte", rx[pos+1], s_ex[idx]);
        check_value("count y byte", rx[pos+2], s_ey[idx]);
        check_value("count isect byte", rx[pos+3], s_ei[idx]);
        check_value("count symdiff byte", rx[pos+4], s_es[idx]);
      end
      pos += 5;
    end
  endtask

  task automatic run_case(input int idx, input int mode, input int k);
    int          p, w, per, cph, bit_i, pwm_ones, expect_pwm;
    int          wrap1, cend, pwm_lo, pwm_hi, stall_lo, stall_hi, flush_at;
    bit          stb_prev, allow, pwm_on;
    logic [31:0] r;
    p = s_p[idx];
    w = s_w[idx];
    per = 1 << (p + w);
    cph = ((1 << p) - 1) >> 1;
    // Cycle of the strobe that closes the first window counted from the write cycle
    wrap1 = 1 + cph + ((1 << w) - 1) * (1 << p);
    cend = 1 + cph + (k * (1 << w) - 1) * (1 << p) + 20;
    pwm_lo = wrap1 + per + 3;
    pwm_hi = pwm_lo + 255;
    pwm_on = (mode == 0) && (s_sel[idx] == 1 || s_sel[idx] == 7);
    stall_lo = wrap1 + 7;
    stall_hi = wrap1 + 6 + 4 * per;
    flush_at = wrap1 + 3;
    rx.delete();
    bit_i = 0;
    pwm_ones = 0;
    stb_prev = 1'b0;
    for (int c = 0; c <= cend; c++) begin
      @(negedge clk);
      wr_config = (c == 0);
      if (c == 0) begin
        sp_exp = p[2:0];
        wl_exp = w[3:0];
        pwm_select = pwm_sel_e'(s_sel[idx][2:0]);
      end
      // Next pattern bit one cycle after each counter strobe
      if (stb_prev) begin
        bit_i = (bit_i + 1) % 16;
      end
      x = s_x[idx][bit_i];
      y = s_y[idx][bit_i];
      stb_prev = (c >= 1) && (((c - 1) % (1 << p)) == cph);
      flush = (mode == 2) && (c == flush_at);
      if (mode == 2 && c == flush_at + 1) begin
        check_value("o_pktfifo_empty", empty, 1);
        win_valid = 1'b0;
      end
      allow = 1'b1;
      if (mode == 1) begin
        if (c >= stall_lo && c <= stall_hi) begin
          allow = 1'b0;
        end else if (c > stall_hi) begin
          r = lcg_next();
          allow = (r[17:16] != 2'b00);
        end
      end
      if (mode == 2 && c <= flush_at) begin
        allow = 1'b0;
      end
      // In the back-pressure case the reader also pops while the FIFO is empty
      pop = allow && (!empty || mode == 1);
      if (pop && !empty) begin
        rx.push_back(fifo_data);
      end
      if (pwm_on && c >= pwm_lo && c <= pwm_hi && pwm) begin
        pwm_ones++;
      end
    end
    if (pwm_on) begin
      expect_pwm = (s_sel[idx] == 1) ? s_ex[idx] : 255 - s_es[idx];
      check_value("o_pwm high cycles", pwm_ones, expect_pwm);
    end
    check_packets(mode, k, idx);
  endtask

  initial begin
    longint total;
    int     last;
    rst_n = 1'b0;
    wr_config = 1'b0;
    sp_exp = '0;
    wl_exp = '0;
    pwm_select = PWM_SEL_WIN_NUM;
    x = 1'b0;
    y = 1'b0;
    pop = 1'b0;
    flush = 1'b0;
    read_stim();
    total = 0;
    for (int i = 0; i < s_p.size(); i++) begin
      total += (s_n[i] + 1) * (longint'(1) << (s_p[i] + s_w[i]));
    end
    last = s_p.size() - 1;
    if (last >= 0) begin
      total += (7 + s_n[last] + 1) * (longint'(1) << (s_p[last] + s_w[last]));
    end
    budget = 2 * total + 2000 + 2 * RST_CYCLES;
    budget_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (RST_CYCLES) begin
      @(negedge clk);
      check_value("o_pktfifo_empty", empty, 1);
      check_value("o_pwm", pwm, 0);
    end
    if (last < 0) begin
      report_failure("no test cases in stimulus file");
    end else begin
      for (int i = 0; i <= last; i++) begin
        run_case(i, 0, s_n[i] + 1);
      end
      run_case(last, 1, 7);
      run_case(last, 2, s_n[last] + 1);
    end
    @(negedge clk);
    pop = 1'b0;
    print_summary();
    if (mismatches + failures == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog sized from the total window time of all cases
  initial begin
    wait (budget_ready);
    repeat (budget) @(posedge clk);
    report_failure("simulation timed out before all cases finished");
    print_summary();
    $display("Regression failed");
    $finish;
  end

endmodule

//--- correlator.f
source/corr_pkg.sv
source/sample_strobe.sv
source/window_counter.sv
source/pkt_builder.sv
source/pkt_fifo.sv
source/pwm_monitor.sv
source/correlator_top.sv
sim/correlator_asserts.sv
sim/correlator_tb.sv

//--- sim/correlator_stim.txt
# p w pwm_sel x_pattern y_pattern windows exp_x exp_y exp_isect exp_symdiff
# p, w, pwm_sel and windows are decimal, patterns and expected bytes are hex
0 5 1 f0f0 ff00 10 04 04 02 04
1 6 7 aaaa 5555 4 08 08 00 10
2 5 0 1234 ffff 3 02 08 02 05
3 8 2 ffff 0f0f 2 40 20 20 20
0 9 3 c3a5 9e71 2 40 48 20 48
